// File: src/chol_params.svh
/* matrix order, element width and fraction bits
 * for the fixed-point Cholesky datapath
 */
`ifndef CHOL_PARAMS_SVH
`define CHOL_PARAMS_SVH

`define CHOL_N    4   // matrix order
`define CHOL_W    32  // element width, Q16.16
`define CHOL_FRAC 16  // fraction bits

`endif

// File: src/chol_pkg.sv
/* chol_pkg: element, index and position types, matrix type,
 * divider/square-root request and controller state enum
 */
`include "chol_params.svh"

package chol_pkg;

    typedef logic signed [`CHOL_W-1:0] elem_t;        // Q16.16
    typedef logic [$clog2(`CHOL_N)-1:0] idx_t;

    typedef struct packed {
        idx_t row;
        idx_t col;
    } pos_t;

    // element (r,c) sits at slot r*N+c
    typedef elem_t [`CHOL_N*`CHOL_N-1:0] matrix_t;

    typedef enum logic {DS_DIV, DS_SQRT} ds_op_e;

    typedef struct packed {
        ds_op_e op;
        elem_t  num;   // numerator or radicand, not yet shifted
        elem_t  den;   // divisor, ignored for sqrt
    } ds_req_t;

    typedef enum logic [2:0] {
        IDLE, LOAD, MAC, ISSUE, WAIT_ACK, WRITE, RELEASE, DONE
    } ctrl_state_e;

endpackage

// File: src/chol_matrix_store.sv
/* chol_matrix_store: captured A and the factor L under construction,
 * four combinational read ports and one L write port
 */
`timescale 1ns/10ps
`include "chol_params.svh"

module chol_matrix_store (
    input  logic               clk,
    input  logic               rst,
    input  logic               capture_i,
    input  chol_pkg::matrix_t  matrix_i,
    input  chol_pkg::pos_t     a_pos_i,
    input  chol_pkg::pos_t     ik_pos_i,
    input  chol_pkg::pos_t     jk_pos_i,
    input  chol_pkg::pos_t     jj_pos_i,
    input  logic               write_i,
    input  chol_pkg::pos_t     wr_pos_i,
    input  chol_pkg::elem_t    wr_data_i,
    output chol_pkg::elem_t    a_o,
    output chol_pkg::elem_t    l_ik_o,
    output chol_pkg::elem_t    l_jk_o,
    output chol_pkg::elem_t    l_jj_o,
    output chol_pkg::matrix_t  factor_o
);
    chol_pkg::matrix_t a_q;
    chol_pkg::matrix_t l_q;

    function automatic int unsigned slot(chol_pkg::pos_t p);
        return p.row * `CHOL_N + p.col;
    endfunction

    always_ff @(posedge clk) begin
        if (capture_i) a_q <= matrix_i;
    end

    // L starts all zero so the upper triangle never needs a write
    always_ff @(posedge clk) begin
        if (rst || capture_i) begin
            l_q <= '0;
        end else if (write_i) begin
            l_q[slot(wr_pos_i)] <= wr_data_i;
        end
    end

    assign a_o      = a_q[slot(a_pos_i)];
    assign l_ik_o   = l_q[slot(ik_pos_i)];
    assign l_jk_o   = l_q[slot(jk_pos_i)];
    assign l_jj_o   = l_q[slot(jj_pos_i)];  // pivot
    assign factor_o = l_q;

endmodule

// File: src/chol_index_counter.sv
/* chol_index_counter: row i, column j and inner index k
 * walking the lower triangle in row-major order
 */
`timescale 1ns/10ps
`include "chol_params.svh"

module chol_index_counter (
    input  logic            clk,
    input  logic            rst,
    input  logic            clear_i,
    input  logic            step_k_i,
    input  logic            step_elem_i,
    output chol_pkg::pos_t  pos_ij_o,
    output chol_pkg::pos_t  pos_ik_o,
    output chol_pkg::pos_t  pos_jk_o,
    output chol_pkg::pos_t  pos_jj_o,
    output logic            k_done_o,
    output logic            on_diag_o,
    output logic            last_elem_o
);
    chol_pkg::idx_t i_q;
    chol_pkg::idx_t j_q;
    chol_pkg::idx_t k_q;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            i_q <= '0;
            j_q <= '0;
            k_q <= '0;
        end else if (step_elem_i) begin
            if (j_q == i_q) begin   // row finished, wrap to next row
                i_q <= i_q + 1'b1;
                j_q <= '0;
            end else begin
                j_q <= j_q + 1'b1;
            end
            k_q <= '0;
        end else if (step_k_i) begin
            k_q <= k_q + 1'b1;
        end
    end

    assign pos_ij_o = '{row: i_q, col: j_q};
    assign pos_ik_o = '{row: i_q, col: k_q};
    assign pos_jk_o = '{row: j_q, col: k_q};
    assign pos_jj_o = '{row: j_q, col: j_q};

    assign k_done_o    = (k_q == j_q);   // sum over k<j complete
    assign on_diag_o   = (i_q == j_q);
    assign last_elem_o = on_diag_o && (i_q == chol_pkg::idx_t'(`CHOL_N - 1));

endmodule

// File: src/chol_mac_unit.sv
/* chol_mac_unit: running sum s = a - sum(prod(op_a, op_b))
 * with Q16.16 products floored by an arithmetic shift
 */
`timescale 1ns/10ps
`include "chol_params.svh"

module chol_mac_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_i,
    input  logic             step_i,
    input  chol_pkg::elem_t  a_i,
    input  chol_pkg::elem_t  op_a_i,
    input  chol_pkg::elem_t  op_b_i,
    output chol_pkg::elem_t  acc_o
);
    logic signed [2*`CHOL_W-1:0] prod_full;
    logic signed [2*`CHOL_W-1:0] prod_sh;

    assign prod_full = op_a_i * op_b_i;          // full signed product
    assign prod_sh   = prod_full >>> `CHOL_FRAC; // back to Q16.16, floor

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_o <= '0;
        end else if (load_i) begin
            acc_o <= a_i;
        end else if (step_i) begin
            acc_o <= acc_o - chol_pkg::elem_t'(prod_sh[`CHOL_W-1:0]);
        end
    end

endmodule

// File: src/chol_divsqrt.sv
/* chol_divsqrt: shared bit-serial restoring divider and
 * digit-by-digit square root, req/ack handshake
 */
`timescale 1ns/10ps
`include "chol_params.svh"

module chol_divsqrt (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid_i,
    input  chol_pkg::ds_req_t  req_i,
    output logic               ack_o,
    output chol_pkg::elem_t    result_o
);
    localparam int W  = `CHOL_W;
    localparam int NW = `CHOL_W + `CHOL_FRAC;  // pre-shifted operand width
    localparam int RW = `CHOL_W + 2;
    localparam int CW = $clog2(NW + 1);

    logic [NW-1:0] sh;     // dividend or radicand, shifted out msb first
    logic [RW-1:0] rem;
    logic [NW-1:0] quo;    // quotient or root bits
    logic [W-1:0]  dmag;
    logic          neg;
    logic          is_sqrt;
    logic          busy;
    logic [CW-1:0] cnt;
    logic [W-1:0]  num_mag;
    logic [W-1:0]  den_mag;
    logic [RW-1:0] rem_sh;
    logic [RW-1:0] trial;
    logic          take;

    assign num_mag = req_i.num[W-1] ? -req_i.num : req_i.num;
    assign den_mag = req_i.den[W-1] ? -req_i.den : req_i.den;

    always_comb begin
        if (is_sqrt) begin
            rem_sh = {rem[RW-3:0], sh[NW-1:NW-2]};  // two radicand bits per step
            trial  = {quo[RW-3:0], 2'b01};          // 4*root + 1
        end else begin
            rem_sh = {rem[RW-2:0], sh[NW-1]};
            trial  = {2'b00, dmag};
        end
        take = (rem_sh >= trial);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            ack_o <= 1'b0;
            cnt   <= '0;
        end else if (busy) begin
            if (cnt != 0) begin
                cnt <= cnt - 1'b1;
            end else begin
                busy  <= 1'b0;   // present result
                ack_o <= 1'b1;
            end
        end else if (ack_o) begin
            if (!req_valid_i) ack_o <= 1'b0;
        end else if (req_valid_i) begin
            busy <= 1'b1;
            cnt  <= (req_i.op == chol_pkg::DS_SQRT) ? CW'(NW / 2) : CW'(NW);
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && !ack_o && req_valid_i) begin
            is_sqrt <= (req_i.op == chol_pkg::DS_SQRT);
            rem     <= '0;
            quo     <= '0;
            dmag    <= den_mag;
            neg     <= req_i.num[W-1] ^ req_i.den[W-1];
            if (req_i.op == chol_pkg::DS_SQRT && req_i.num <= 0) begin
                sh <= '0;   // non-positive radicand gives root 0
            end else begin
                sh <= {num_mag, {`CHOL_FRAC{1'b0}}};
            end
        end else if (busy && cnt != 0) begin
            sh  <= is_sqrt ? {sh[NW-3:0], 2'b00} : {sh[NW-2:0], 1'b0};
            rem <= take ? rem_sh - trial : rem_sh;
            quo <= {quo[NW-2:0], take};
        end else if (busy) begin
            // magnitude quotient negated gives truncation toward zero
            result_o <= (is_sqrt || !neg) ? quo[W-1:0] : -quo[W-1:0];
        end
    end

endmodule

// File: src/chol_ctrl.sv
/* chol_ctrl: element sequencing FSM and the outer
 * four-phase req/ack handshake
 */
`timescale 1ns/10ps

module chol_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  logic               k_done_i,
    input  logic               on_diag_i,
    input  logic               last_elem_i,
    input  chol_pkg::elem_t    acc_i,
    input  chol_pkg::elem_t    pivot_i,
    input  logic               ds_ack_i,
    output logic               ack_o,
    output logic               capture_o,
    output logic               clear_o,
    output logic               step_k_o,
    output logic               step_elem_o,
    output logic               mac_load_o,
    output logic               mac_step_o,
    output logic               ds_req_valid_o,
    output logic               write_o,
    output chol_pkg::ds_req_t  ds_req_o
);
    chol_pkg::ctrl_state_e state_q;
    chol_pkg::ctrl_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst) state_q <= chol_pkg::IDLE;
        else     state_q <= state_d;
    end

    always_comb begin
        state_d        = state_q;
        ack_o          = 1'b0;
        capture_o      = 1'b0;
        clear_o        = 1'b0;
        step_k_o       = 1'b0;
        step_elem_o    = 1'b0;
        mac_load_o     = 1'b0;
        mac_step_o     = 1'b0;
        ds_req_valid_o = 1'b0;
        write_o        = 1'b0;
        case (state_q)
            chol_pkg::IDLE: begin
                if (req_i) begin
                    capture_o = 1'b1;   // latch A, clear L and indices
                    clear_o   = 1'b1;
                    state_d   = chol_pkg::LOAD;
                end
            end
            chol_pkg::LOAD: begin
                mac_load_o = 1'b1;  // acc <= a_ij
                state_d    = k_done_i ? chol_pkg::ISSUE : chol_pkg::MAC;
            end
            chol_pkg::MAC: begin
                mac_step_o = !k_done_i;  // one product per cycle
                step_k_o   = !k_done_i;
                if (k_done_i) state_d = chol_pkg::ISSUE;
            end
            chol_pkg::ISSUE: begin
                ds_req_valid_o = 1'b1;
                state_d        = chol_pkg::WAIT_ACK;
            end
            chol_pkg::WAIT_ACK: begin
                ds_req_valid_o = 1'b1;
                if (ds_ack_i) state_d = chol_pkg::WRITE;
            end
            chol_pkg::WRITE: begin
                write_o = 1'b1;   // result held while ack is up
                state_d = chol_pkg::RELEASE;
            end
            chol_pkg::RELEASE: begin
                if (!ds_ack_i) begin
                    step_elem_o = !last_elem_i;
                    state_d     = last_elem_i ? chol_pkg::DONE : chol_pkg::LOAD;
                end
            end
            default: begin  // DONE, factor valid until req drops
                ack_o = 1'b1;
                if (!req_i) state_d = chol_pkg::IDLE;
            end
        endcase
    end

    // sqrt on the diagonal, divide by l_jj below it
    assign ds_req_o.op  = on_diag_i ? chol_pkg::DS_SQRT : chol_pkg::DS_DIV;
    assign ds_req_o.num = acc_i;
    assign ds_req_o.den = pivot_i;

endmodule

// File: src/chol_top.sv
/* chol_top: fixed-point 4x4 Cholesky factorization, controller,
 * index counter, matrix store, accumulator and divider/sqrt unit
 */
`timescale 1ns/10ps

module chol_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  chol_pkg::matrix_t  matrix_i,
    output logic               ack_o,
    output chol_pkg::matrix_t  factor_o
);
    logic capture, clear, step_k, step_elem, mac_load, mac_step, write;
    logic ds_req_valid, ds_ack, k_done, on_diag, last_elem;
    chol_pkg::ds_req_t ds_req;
    chol_pkg::elem_t   ds_result, acc, a_ij, l_ik, l_jk, l_jj;
    chol_pkg::pos_t    pos_ij, pos_ik, pos_jk, pos_jj;

    chol_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req_i(req_i), .k_done_i(k_done), .on_diag_i(on_diag),
        .last_elem_i(last_elem), .acc_i(acc), .pivot_i(l_jj), .ds_ack_i(ds_ack),
        .ack_o(ack_o), .capture_o(capture), .clear_o(clear), .step_k_o(step_k),
        .step_elem_o(step_elem), .mac_load_o(mac_load), .mac_step_o(mac_step),
        .ds_req_valid_o(ds_req_valid), .write_o(write), .ds_req_o(ds_req)
    );

    chol_index_counter u_cnt (
        .clk(clk), .rst(rst), .clear_i(clear), .step_k_i(step_k),
        .step_elem_i(step_elem), .pos_ij_o(pos_ij), .pos_ik_o(pos_ik),
        .pos_jk_o(pos_jk), .pos_jj_o(pos_jj), .k_done_o(k_done),
        .on_diag_o(on_diag), .last_elem_o(last_elem)
    );

    // a_ij and the result share the current element position
    chol_matrix_store u_store (
        .clk(clk), .rst(rst), .capture_i(capture), .matrix_i(matrix_i),
        .a_pos_i(pos_ij), .ik_pos_i(pos_ik), .jk_pos_i(pos_jk), .jj_pos_i(pos_jj),
        .write_i(write), .wr_pos_i(pos_ij), .wr_data_i(ds_result), .a_o(a_ij),
        .l_ik_o(l_ik), .l_jk_o(l_jk), .l_jj_o(l_jj), .factor_o(factor_o)
    );

    chol_mac_unit u_mac (
        .clk(clk), .rst(rst), .load_i(mac_load), .step_i(mac_step),
        .a_i(a_ij), .op_a_i(l_ik), .op_b_i(l_jk), .acc_o(acc)
    );

    chol_divsqrt u_divsqrt (
        .clk(clk), .rst(rst), .req_valid_i(ds_req_valid), .req_i(ds_req),
        .ack_o(ds_ack), .result_o(ds_result)
    );

endmodule

// File: testbench/chol_tb.sv
/* chol_tb: clock, reset, fixed-point Cholesky reference model
 * and directed tests for the four-phase top level
 */
`timescale 1ns/10ps
`include "chol_params.svh"

module chol_tb;
    localparam int          PERIOD  = 4;
    localparam int          TIMEOUT = 4000;   // cycles per wait
    localparam logic [31:0] SEED    = 32'he2b8;
    localparam int          N       = `CHOL_N;
    localparam int          ONE     = 1 << `CHOL_FRAC;

    logic              clk;
    logic              rst;
    logic              req_i;
    chol_pkg::matrix_t matrix_i;
    logic              ack_o;
    chol_pkg::matrix_t factor_o;

    chol_top UUT (
        .clk(clk), .rst(rst), .req_i(req_i), .matrix_i(matrix_i),
        .ack_o(ack_o), .factor_o(factor_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string test, input string what, input logic exp,
                             input logic act);
        assert (act === exp) else begin
            $display("Mismatch in %s: %s expected %b, actual %b", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_matrix(input string test, input chol_pkg::matrix_t exp,
                                input chol_pkg::matrix_t act);
        for (int s = 0; s < N * N; s++) begin
            assert (act[s] === exp[s]) else begin
                $display("Mismatch in %s: L[%0d][%0d] expected %h, actual %h",
                         test, s / N, s % N, exp[s], act[s]);
                abort_run();
            end
        end
    endtask

    // floor square root by bisection
    function automatic longint isqrt(input longint x);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = longint'(1) << 32;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= x) lo = mid;
            else hi = mid - 1;
        end
        return lo;
    endfunction

    // row-major walk with sums wrapping at 32 bits
    function automatic chol_pkg::matrix_t model_factor(input chol_pkg::matrix_t a);
        chol_pkg::matrix_t l;
        longint s;
        longint p;
        l = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                s = longint'($signed(a[i*N+j]));
                for (int k = 0; k < j; k++) begin
                    p = longint'($signed(l[i*N+k])) * longint'($signed(l[j*N+k]));
                    s = longint'(int'(s - (p >>> `CHOL_FRAC)));
                end
                if (i == j) begin
                    l[i*N+j] = (s <= 0) ? '0 : chol_pkg::elem_t'(isqrt(s <<< `CHOL_FRAC));
                end else begin
                    p = (s <<< `CHOL_FRAC) / longint'($signed(l[j*N+j]));   // toward zero
                    l[i*N+j] = chol_pkg::elem_t'(p);
                end
            end
        end
        return l;
    endfunction

    task automatic wait_ack(input logic level, input string test);
        int cycles;
        cycles = 0;
        while (ack_o !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout in %s: ack_o did not go %s within %0d cycles",
                         test, level ? "high" : "low", TIMEOUT);
                abort_run();
            end
        end
    endtask

    // full four-phase transaction with the factor sampled while ack is high
    task automatic transact(input chol_pkg::matrix_t a, input string test,
                            output chol_pkg::matrix_t got);
        matrix_i = a;
        req_i    = 1'b1;
        wait_ack(1'b1, test);
        got   = factor_o;
        req_i = 1'b0;
        wait_ack(1'b0, test);
    endtask

    task automatic make_random(output chol_pkg::matrix_t a);
        int v;
        int sum;
        a = '0;
        for (int i = 1; i < N; i++) begin
            for (int j = 0; j < i; j++) begin
                v = int'($urandom % 32'h80000) - 32'h40000;   // within +-4.0
                a[i*N+j] = v;
                a[j*N+i] = v;
            end
        end
        for (int i = 0; i < N; i++) begin
            sum = ONE + int'($urandom % 32'h40000);   // strict dominance margin
            for (int j = 0; j < N; j++) begin
                if (j != i) sum += ($signed(a[i*N+j]) < 0) ? -$signed(a[i*N+j]) : a[i*N+j];
            end
            a[i*N+i] = sum;
        end
    endtask

    task automatic test_reset_state();
        check_bit("reset", "ack_o", 1'b0, ack_o);
        check_matrix("reset", '0, factor_o);
    endtask

    task automatic test_diagonal();
        chol_pkg::matrix_t a;
        chol_pkg::matrix_t exp;
        chol_pkg::matrix_t got;
        a   = '0;
        exp = '0;
        for (int i = 0; i < N; i++) begin
            a[i*N+i]   = (i + 2) * (i + 2) * ONE;
            exp[i*N+i] = (i + 2) * ONE;   // 2, 3, 4, 5
        end
        transact(a, "diagonal", got);
        check_matrix("diagonal", exp, got);
    endtask

    task automatic test_dense();
        chol_pkg::matrix_t a;
        chol_pkg::matrix_t got;
        int lower [10];
        int n;
        // A = L*L' in quarters for L rows (2) (1,3) (-1,2,4) (0.5,1,-1,2)
        lower = '{16, 8, 40, -8, 20, 84, 4, 14, -10, 25};
        a = '0;
        n = 0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                a[i*N+j] = lower[n] * (ONE / 4);
                a[j*N+i] = lower[n] * (ONE / 4);
                n++;
            end
        end
        transact(a, "dense", got);
        check_matrix("dense", model_factor(a), got);
    endtask

    task automatic test_random(input int count);
        chol_pkg::matrix_t a;
        chol_pkg::matrix_t got;
        string name;
        for (int n = 0; n < count; n++) begin
            name = $sformatf("random_%0d", n);
            make_random(a);
            transact(a, name, got);
            check_matrix(name, model_factor(a), got);
        end
    endtask

    task automatic test_backpressure();
        chol_pkg::matrix_t a;
        chol_pkg::matrix_t held;
        chol_pkg::matrix_t got;
        make_random(a);
        matrix_i = a;
        req_i    = 1'b1;
        wait_ack(1'b1, "backpressure");
        held = factor_o;
        check_matrix("backpressure", model_factor(a), held);
        repeat (20) begin
            @(posedge clk);
            #1;
            check_bit("backpressure", "ack_o while req held", 1'b1, ack_o);
            check_matrix("backpressure", held, factor_o);
        end
        req_i = 1'b0;
        check_bit("backpressure", "ack_o as req drops", 1'b1, ack_o);
        wait_ack(1'b0, "backpressure");
        make_random(a);   // a different matrix must show no residue
        transact(a, "after_backpressure", got);
        check_matrix("after_backpressure", model_factor(a), got);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        req_i    = 1'b0;
        matrix_i = '0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_diagonal();
        test_dense();
        test_random(8);
        test_backpressure();
        $display("No errors");
        $finish;
    end

endmodule

// File: chol.f
+incdir+src
src/chol_pkg.sv
src/chol_matrix_store.sv
src/chol_index_counter.sv
src/chol_mac_unit.sv
src/chol_divsqrt.sv
src/chol_ctrl.sv
src/chol_top.sv
testbench/chol_tb.sv

// File: Bender.yml
package:
  name: chol

sources:
  - include_dirs:
      - src
    files:
      - src/chol_pkg.sv
      - src/chol_matrix_store.sv
      - src/chol_index_counter.sv
      - src/chol_mac_unit.sv
      - src/chol_divsqrt.sv
      - src/chol_ctrl.sv
      - src/chol_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/chol_tb.sv
